/* verilog/dispatch_pkg.sv */
package dispatch_pkg;

	// Data word for operands, PC values and register contents
	typedef logic [31:0] word_t;

	// General or system register pointer
	typedef logic [4:0] reg_ptr_t;

	// Execute command code
	typedef logic [4:0] cmd_t;

	// System register indices
	localparam reg_ptr_t SYSREG_CPUIDR = 5'd0;
	localparam reg_ptr_t SYSREG_COREIDR = 5'd1;
	localparam reg_ptr_t SYSREG_TIDR = 5'd2;
	localparam reg_ptr_t SYSREG_PCR = 5'd4;
	localparam reg_ptr_t SYSREG_SPR = 5'd5;
	localparam reg_ptr_t SYSREG_PSR = 5'd6;
	localparam reg_ptr_t SYSREG_PPSR = 5'd12;
	localparam reg_ptr_t SYSREG_PPCR = 5'd13;

	// Processor ID in the upper half and revision in the lower half
	localparam word_t PROCESSOR_ID_REV = {16'h4d49, 16'h0102};

	// PCR as a source points one instruction back
	localparam word_t PC_STEP = 32'd4;

endpackage

/* verilog/gr_file.sv */
`timescale 1ns/1ps

module gr_file import dispatch_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic pipeline_stop,
	input logic wb_valid,
	input logic wb_writeback,
	input logic wb_destination_sysreg,
	input reg_ptr_t wb_destination,
	input word_t wb_data,
	input reg_ptr_t rd_ptr0,
	input reg_ptr_t rd_ptr1,
	output word_t rd_data0,
	output word_t rd_data1
);

	word_t regs [0:31];
	logic wr_en;

	// Only general register targets land here
	assign wr_en = wb_valid && wb_writeback && !wb_destination_sysreg && !pipeline_stop;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb_destination] <= wb_data;
		end
	end

	assign rd_data0 = regs[rd_ptr0];
	assign rd_data1 = regs[rd_ptr1];

	// A known pointer from decode must always read back a known word
	a_rd_data0_known: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!$isunknown(rd_ptr0) |-> !$isunknown(rd_data0)
	);

endmodule

/* verilog/sysreg_file.sv */
`timescale 1ns/1ps

module sysreg_file import dispatch_pkg::*; #(
	parameter word_t CORE_ID = 32'h0
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic pipeline_stop,
	input logic register_lock,
	input logic set_irq_mode,
	input logic clr_irq_mode,
	input logic ppcr_set,
	input word_t ppcr_load,
	input logic wb_valid,
	input logic wb_writeback,
	input logic wb_destination_sysreg,
	input reg_ptr_t wb_destination,
	input word_t wb_data,
	input logic wb_spr_writeback,
	input word_t wb_spr,
	input word_t wb_pc,
	input logic wb_branch,
	input word_t wb_branch_pc,
	input logic rd_active0,
	input logic rd_active1,
	input reg_ptr_t rd_ptr0,
	input reg_ptr_t rd_ptr1,
	input word_t prev_pc,
	output word_t rd_data0,
	output word_t rd_data1,
	output logic rd_valid0,
	output logic rd_valid1,
	output word_t pcr,
	output word_t psr,
	output word_t ppsr,
	output word_t ppcr,
	output word_t spr,
	output word_t tidr
);

	logic wb_sys_ok;
	logic tidr_hit;
	logic spr_hit;
	logic psr_hit;
	logic ppsr_hit;
	logic ppcr_hit;
	logic pcr_load;
	logic spr_direct;
	word_t pcr_read;

	// Direct writeback into a system register
	assign wb_sys_ok = !pipeline_stop && wb_valid && wb_destination_sysreg && wb_writeback;
	assign tidr_hit = wb_sys_ok && (wb_destination == SYSREG_TIDR);
	assign spr_hit = wb_sys_ok && (wb_destination == SYSREG_SPR);
	assign psr_hit = wb_sys_ok && (wb_destination == SYSREG_PSR);
	assign ppsr_hit = wb_sys_ok && (wb_destination == SYSREG_PPSR);
	assign ppcr_hit = wb_sys_ok && (wb_destination == SYSREG_PPCR);

	assign pcr_load = wb_valid && !pipeline_stop && !register_lock;
	assign spr_direct = !pipeline_stop && wb_valid && wb_spr_writeback;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pcr <= '0;
			spr <= '0;
			tidr <= '0;
			ppcr <= '0;
		end else begin
			if (pcr_load) begin
				pcr <= wb_branch ? wb_branch_pc : wb_pc;
			end
			if (spr_direct) begin
				spr <= wb_spr;
			end else if (spr_hit) begin
				spr <= wb_data;
			end
			if (tidr_hit) begin
				tidr <= wb_data;
			end
			if (ppcr_set) begin
				ppcr <= ppcr_load;
			end else if (ppcr_hit) begin
				ppcr <= wb_data;
			end
		end
	end

	// IRQ entry saves PSR and masks bits 6, 5 and 2; IRQ exit restores it
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			psr <= '0;
			ppsr <= '0;
		end else begin
			if (set_irq_mode) begin
				psr <= {psr[31:7], 2'b00, psr[4:3], 1'b0, psr[1:0]};
			end else if (clr_irq_mode) begin
				psr <= ppsr;
			end else if (psr_hit) begin
				psr <= wb_data;
			end
			if (set_irq_mode) begin
				ppsr <= psr;
			end else if (ppsr_hit) begin
				ppsr <= wb_data;
			end
		end
	end

	assign pcr_read = prev_pc - PC_STEP;

	function automatic logic [32:0] read_sysreg(input logic active, input reg_ptr_t ptr);
		logic [32:0] result;
		result = '0;
		if (active) begin
			case (ptr)
				SYSREG_CPUIDR: result = {1'b1, PROCESSOR_ID_REV};
				SYSREG_COREIDR: result = {1'b1, CORE_ID};
				SYSREG_TIDR: result = {1'b1, tidr};
				SYSREG_PCR: result = {1'b1, pcr_read};
				SYSREG_SPR: result = {1'b1, spr};
				SYSREG_PSR: result = {1'b1, psr};
				SYSREG_PPSR: result = {1'b1, ppsr};
				SYSREG_PPCR: result = {1'b1, ppcr};
				default: result = '0;
			endcase
		end
		return result;
	endfunction

	always_comb begin
		{rd_valid0, rd_data0} = read_sysreg(rd_active0, rd_ptr0);
	end

	always_comb begin
		{rd_valid1, rd_data1} = read_sysreg(rd_active1, rd_ptr1);
	end

	// The free control unit never enters and leaves IRQ mode at once
	a_irq_mode_exclusive: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!(set_irq_mode && clr_irq_mode)
	);

endmodule

/* verilog/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass import dispatch_pkg::*; (
	input reg_ptr_t rd_ptr,
	input logic rd_sysreg,
	input logic use_imm,
	input word_t imm,
	input word_t gr_data,
	input word_t sr_data,
	input logic sr_valid,
	input logic wb_valid,
	input logic wb_writeback,
	input logic wb_destination_sysreg,
	input logic wb_spr_writeback,
	input reg_ptr_t wb_destination,
	input word_t wb_data,
	input word_t wb_spr,
	input word_t wb_pc,
	output word_t operand
);

	logic fwd_hit;
	word_t fwd_data;

	// Forward from writeback
	always_comb begin
		fwd_hit = 1'b0;
		fwd_data = '0;
		if (wb_valid) begin
			if (rd_sysreg) begin
				if (wb_destination_sysreg) begin
					if (rd_ptr == SYSREG_PCR) begin
						fwd_hit = 1'b1;
						fwd_data = wb_pc;
					end else if (rd_ptr == SYSREG_SPR && wb_spr_writeback) begin
						fwd_hit = 1'b1;
						fwd_data = wb_spr;
					end else if (rd_ptr == wb_destination && wb_writeback) begin
						fwd_hit = 1'b1;
						fwd_data = wb_data;
					end
				end
			end else if (rd_ptr == wb_destination && !wb_destination_sysreg
					&& wb_writeback) begin
				fwd_hit = 1'b1;
				fwd_data = wb_data;
			end
		end
	end

	always_comb begin
		if (use_imm) begin
			operand = imm;
		end else if (fwd_hit) begin
			operand = fwd_data;
		end else if (rd_sysreg && sr_valid) begin
			operand = sr_data;
		end else begin
			operand = gr_data;
		end
	end

endmodule

/* verilog/dispatch_latch.sv */
`timescale 1ns/1ps

module dispatch_latch import dispatch_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic refresh,
	input logic pipeline_stop,
	input logic next_lock,
	input logic wb_valid,
	input logic prev_valid,
	input logic prev_destination_sysreg,
	input logic prev_writeback,
	input logic prev_ex_branch,
	input reg_ptr_t prev_destination,
	input cmd_t prev_cmd,
	input word_t prev_pc,
	input word_t operand0,
	input word_t operand1,
	output logic next_valid,
	output logic next_destination_sysreg,
	output logic next_writeback,
	output logic next_ex_branch,
	output reg_ptr_t next_destination,
	output cmd_t next_cmd,
	output word_t next_pc,
	output word_t next_source0,
	output word_t next_source1,
	output logic exception_lock
);

	logic valid_q;
	logic pcr_valid;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
			next_destination_sysreg <= 1'b0;
			next_writeback <= 1'b0;
			next_ex_branch <= 1'b0;
			next_destination <= '0;
			next_cmd <= '0;
			next_pc <= '0;
			next_source0 <= '0;
			next_source1 <= '0;
		end else if (refresh) begin
			valid_q <= 1'b0;
			next_destination_sysreg <= 1'b0;
			next_writeback <= 1'b0;
			next_ex_branch <= 1'b0;
			next_destination <= '0;
			next_cmd <= '0;
			next_pc <= '0;
			next_source0 <= '0;
			next_source1 <= '0;
		end else if (!next_lock) begin
			valid_q <= prev_valid;
			next_destination_sysreg <= prev_destination_sysreg;
			next_writeback <= prev_writeback;
			next_ex_branch <= prev_ex_branch;
			next_destination <= prev_destination;
			next_cmd <= prev_cmd;
			next_pc <= prev_pc;
			next_source0 <= operand0;
			next_source1 <= operand1;
		end
	end

	// PCR is trusted once the first writeback has passed
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pcr_valid <= 1'b0;
		end else if (refresh) begin
			pcr_valid <= 1'b0;
		end else if (!pcr_valid && wb_valid && !pipeline_stop) begin
			pcr_valid <= 1'b1;
		end
	end

	assign next_valid = valid_q && !next_lock;
	assign exception_lock = !pcr_valid || !valid_q || next_ex_branch;

	// Held instruction stays put across a stall
	a_hold_under_lock: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		next_lock && !refresh |=> $stable(next_pc) && $stable(next_source0)
			&& $stable(next_source1)
	);

endmodule

/* verilog/dispatch.sv */
`timescale 1ns/1ps

module dispatch import dispatch_pkg::*; #(
	parameter word_t CORE_ID = 32'h0
) (
	input logic iCLOCK,
	input logic inRESET,
	// Free control unit
	input logic pipeline_stop,
	input logic register_lock,
	input logic refresh,
	input logic set_irq_mode,
	input logic clr_irq_mode,
	input logic ppcr_set,
	input word_t ppcr_load,
	output logic exception_lock,
	output word_t pcr,
	output word_t psr,
	output word_t ppsr,
	output word_t ppcr,
	output word_t spr,
	output word_t tidr,
	// Decode side
	input logic prev_valid,
	input logic prev_source0_active,
	input logic prev_source1_active,
	input logic prev_source0_sysreg,
	input logic prev_source1_sysreg,
	input reg_ptr_t prev_source0,
	input word_t prev_source1,
	input logic prev_source1_imm,
	input logic prev_destination_sysreg,
	input reg_ptr_t prev_destination,
	input logic prev_writeback,
	input cmd_t prev_cmd,
	input logic prev_ex_branch,
	input word_t prev_pc,
	output logic previous_lock,
	// Execute side
	output logic next_valid,
	output logic next_destination_sysreg,
	output reg_ptr_t next_destination,
	output logic next_writeback,
	output cmd_t next_cmd,
	output word_t next_source0,
	output word_t next_source1,
	output logic next_ex_branch,
	output word_t next_pc,
	input logic next_lock,
	// Writeback
	input logic wb_valid,
	input word_t wb_data,
	input reg_ptr_t wb_destination,
	input logic wb_destination_sysreg,
	input logic wb_writeback,
	input logic wb_spr_writeback,
	input word_t wb_spr,
	input word_t wb_pc,
	input logic wb_branch,
	input word_t wb_branch_pc
);

	word_t gr_data0;
	word_t gr_data1;
	word_t sr_data0;
	word_t sr_data1;
	logic sr_valid0;
	logic sr_valid1;
	word_t operand0;
	word_t operand1;

	assign previous_lock = next_lock;

	gr_file u_gr_file (
		.rd_ptr0(prev_source0),
		.rd_ptr1(prev_source1[4:0]),
		.rd_data0(gr_data0),
		.rd_data1(gr_data1),
		.*
	);

	sysreg_file #(
		.CORE_ID(CORE_ID)
	) u_sysreg_file (
		.rd_active0(prev_source0_active),
		.rd_active1(prev_source1_active),
		.rd_ptr0(prev_source0),
		.rd_ptr1(prev_source1[4:0]),
		.rd_data0(sr_data0),
		.rd_data1(sr_data1),
		.rd_valid0(sr_valid0),
		.rd_valid1(sr_valid1),
		.*
	);

	// Source 0 never carries an immediate
	operand_bypass u_bypass0 (
		.rd_ptr(prev_source0),
		.rd_sysreg(prev_source0_sysreg),
		.use_imm(1'b0),
		.imm(32'h0),
		.gr_data(gr_data0),
		.sr_data(sr_data0),
		.sr_valid(sr_valid0),
		.operand(operand0),
		.*
	);

	operand_bypass u_bypass1 (
		.rd_ptr(prev_source1[4:0]),
		.rd_sysreg(prev_source1_sysreg),
		.use_imm(prev_source1_imm),
		.imm(prev_source1),
		.gr_data(gr_data1),
		.sr_data(sr_data1),
		.sr_valid(sr_valid1),
		.operand(operand1),
		.*
	);

	dispatch_latch u_latch (
		.*
	);

endmodule

/* tb/tb_dispatch.sv */
`timescale 1ns/1ps

module tb_dispatch import dispatch_pkg::*; ();

	localparam word_t CORE_ID = 32'd3;
	localparam int WAIT_LIMIT = 16;

	logic iCLOCK, inRESET;
	logic pipeline_stop, register_lock, refresh;
	logic set_irq_mode, clr_irq_mode, ppcr_set;
	word_t ppcr_load;
	logic exception_lock;
	word_t pcr, psr, ppsr, ppcr, spr, tidr;
	logic prev_valid, prev_source0_active, prev_source1_active;
	logic prev_source0_sysreg, prev_source1_sysreg, prev_source1_imm;
	reg_ptr_t prev_source0;
	word_t prev_source1;
	logic prev_destination_sysreg, prev_writeback, prev_ex_branch;
	reg_ptr_t prev_destination;
	cmd_t prev_cmd;
	word_t prev_pc;
	logic previous_lock;
	logic next_valid, next_destination_sysreg, next_writeback, next_ex_branch;
	reg_ptr_t next_destination;
	cmd_t next_cmd;
	word_t next_source0, next_source1, next_pc;
	logic next_lock;
	logic wb_valid, wb_destination_sysreg, wb_writeback, wb_spr_writeback, wb_branch;
	reg_ptr_t wb_destination;
	word_t wb_data, wb_spr, wb_pc, wb_branch_pc;

	// Expected values armed for one edge by their flags
	logic chk_src0, chk_src1, chk_valid, chk_elock, chk_npc, chk_fields;
	logic chk_pcr, chk_psr, chk_ppsr, chk_ppcr, chk_spr, chk_tidr;
	word_t exp_src0, exp_src1, exp_npc, exp_pcr, exp_psr, exp_ppsr, exp_ppcr;
	word_t exp_spr, exp_tidr;
	logic exp_valid, exp_elock;
	reg_ptr_t exp_dest;
	cmd_t exp_cmd;
	logic exp_writeback, exp_dest_sys, exp_branch;

	// Random fields of the last dispatch
	reg_ptr_t last_dest;
	cmd_t last_cmd;

	int value_errors = 0;
	int timeouts = 0;
	logic [31:0] lfsr_state = 32'hea28;

	dispatch #(
		.CORE_ID(CORE_ID)
	) u_dut (
		.*
	);

	always #4 iCLOCK = ~iCLOCK;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		value_errors++;
		$display("** Error: %s = %h, expected %h at %0t", name, got, want, $time);
	endtask

	a_next_source0: assert property (@(posedge iCLOCK) chk_src0 |-> next_source0 == exp_src0)
		else report_mismatch("next_source0", $sampled(next_source0), $sampled(exp_src0));
	a_next_source1: assert property (@(posedge iCLOCK) chk_src1 |-> next_source1 == exp_src1)
		else report_mismatch("next_source1", $sampled(next_source1), $sampled(exp_src1));
	a_next_valid: assert property (@(posedge iCLOCK) chk_valid |-> next_valid == exp_valid)
		else report_mismatch("next_valid", $sampled(next_valid), $sampled(exp_valid));
	a_exception_lock: assert property (@(posedge iCLOCK) chk_elock |-> exception_lock == exp_elock)
		else report_mismatch("exception_lock", $sampled(exception_lock), $sampled(exp_elock));
	a_next_pc: assert property (@(posedge iCLOCK) chk_npc |-> next_pc == exp_npc)
		else report_mismatch("next_pc", $sampled(next_pc), $sampled(exp_npc));
	a_next_destination: assert property (@(posedge iCLOCK)
		chk_fields |-> next_destination == exp_dest)
		else report_mismatch("next_destination", $sampled(next_destination),
			$sampled(exp_dest));
	a_next_cmd: assert property (@(posedge iCLOCK) chk_fields |-> next_cmd == exp_cmd)
		else report_mismatch("next_cmd", $sampled(next_cmd), $sampled(exp_cmd));
	a_next_writeback: assert property (@(posedge iCLOCK)
		chk_fields |-> next_writeback == exp_writeback)
		else report_mismatch("next_writeback", $sampled(next_writeback),
			$sampled(exp_writeback));
	a_next_destination_sysreg: assert property (@(posedge iCLOCK)
		chk_fields |-> next_destination_sysreg == exp_dest_sys)
		else report_mismatch("next_destination_sysreg", $sampled(next_destination_sysreg),
			$sampled(exp_dest_sys));
	a_next_ex_branch: assert property (@(posedge iCLOCK)
		chk_fields |-> next_ex_branch == exp_branch)
		else report_mismatch("next_ex_branch", $sampled(next_ex_branch), $sampled(exp_branch));
	a_pcr: assert property (@(posedge iCLOCK) chk_pcr |-> pcr == exp_pcr)
		else report_mismatch("pcr", $sampled(pcr), $sampled(exp_pcr));
	a_psr: assert property (@(posedge iCLOCK) chk_psr |-> psr == exp_psr)
		else report_mismatch("psr", $sampled(psr), $sampled(exp_psr));
	a_ppsr: assert property (@(posedge iCLOCK) chk_ppsr |-> ppsr == exp_ppsr)
		else report_mismatch("ppsr", $sampled(ppsr), $sampled(exp_ppsr));
	a_ppcr: assert property (@(posedge iCLOCK) chk_ppcr |-> ppcr == exp_ppcr)
		else report_mismatch("ppcr", $sampled(ppcr), $sampled(exp_ppcr));
	a_spr: assert property (@(posedge iCLOCK) chk_spr |-> spr == exp_spr)
		else report_mismatch("spr", $sampled(spr), $sampled(exp_spr));
	a_tidr: assert property (@(posedge iCLOCK) chk_tidr |-> tidr == exp_tidr)
		else report_mismatch("tidr", $sampled(tidr), $sampled(exp_tidr));
	a_previous_lock: assert property (@(posedge iCLOCK) previous_lock == next_lock)
		else report_mismatch("previous_lock", $sampled(previous_lock), $sampled(next_lock));

	task automatic step();
		@(posedge iCLOCK);
		#1;
	endtask

	task automatic clear_checks();
		{chk_src0, chk_src1, chk_valid, chk_elock, chk_npc, chk_fields} = '0;
		{chk_pcr, chk_psr, chk_ppsr, chk_ppcr, chk_spr, chk_tidr} = '0;
	endtask

	// Armed checks fire at the coming edge
	task automatic end_check();
		step();
		clear_checks();
	endtask

	task automatic clear_wb();
		wb_valid = 1'b0;
		wb_writeback = 1'b0;
		wb_destination_sysreg = 1'b0;
		wb_spr_writeback = 1'b0;
		wb_branch = 1'b0;
	endtask

	task automatic drive_wb(input logic sys, input reg_ptr_t dest, input word_t data,
			input word_t pc);
		wb_valid = 1'b1;
		wb_writeback = 1'b1;
		wb_destination_sysreg = sys;
		wb_destination = dest;
		wb_data = data;
		wb_pc = pc;
		wb_branch = 1'b0;
	endtask

	task automatic drive_dispatch(input reg_ptr_t src0, input logic src0_sys, input word_t src1,
			input logic src1_sys, input logic src1_imm, input word_t pc, input logic branch);
		logic [31:0] r;
		take_bits(10, r);
		prev_valid = 1'b1;
		prev_source0_active = 1'b1;
		prev_source0_sysreg = src0_sys;
		prev_source0 = src0;
		prev_source1_active = !src1_imm;
		prev_source1_sysreg = src1_sys;
		prev_source1_imm = src1_imm;
		prev_source1 = src1;
		prev_pc = pc;
		prev_ex_branch = branch;
		prev_writeback = 1'b1;
		prev_destination_sysreg = 1'b0;
		prev_destination = r[4:0];
		prev_cmd = r[9:5];
		last_dest = r[4:0];
		last_cmd = r[9:5];
	endtask

	task automatic wait_elock_low();
		int cycles;
		cycles = 0;
		while (exception_lock !== 1'b0 && cycles < WAIT_LIMIT) begin
			step();
			cycles++;
		end
		if (exception_lock !== 1'b0) begin
			timeouts++;
			$display("Timed out waiting for exception_lock to fall");
		end
	endtask

	task automatic wait_next_valid();
		int cycles;
		cycles = 0;
		do begin
			step();
			cycles++;
		end while (next_valid !== 1'b1 && cycles < WAIT_LIMIT);
		if (next_valid !== 1'b1) begin
			timeouts++;
			$display("Timed out waiting for next_valid after the lock dropped");
		end
	endtask

	initial begin
		#200000;
		$display("Simulation ran past its time limit");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r, d1, d2, imm, pc, pa, pb, v;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		{pipeline_stop, register_lock, refresh, next_lock} = '0;
		{set_irq_mode, clr_irq_mode, ppcr_set} = '0;
		ppcr_load = '0;
		{prev_valid, prev_source0_active, prev_source1_active} = '0;
		{prev_source0_sysreg, prev_source1_sysreg, prev_source1_imm} = '0;
		{prev_destination_sysreg, prev_writeback, prev_ex_branch} = '0;
		prev_source0 = '0;
		prev_source1 = '0;
		prev_destination = '0;
		prev_cmd = '0;
		prev_pc = '0;
		clear_wb();
		wb_destination = '0;
		{wb_data, wb_spr, wb_pc, wb_branch_pc} = '0;
		clear_checks();
		repeat (8) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;

		// Reset state
		{exp_src0, exp_src1, exp_npc, exp_pcr, exp_psr} = '0;
		{exp_ppsr, exp_ppcr, exp_spr, exp_tidr} = '0;
		exp_valid = 1'b0;
		exp_elock = 1'b1;
		exp_dest = '0;
		exp_cmd = '0;
		{exp_writeback, exp_dest_sys, exp_branch} = '0;
		{chk_src0, chk_src1, chk_valid, chk_elock, chk_npc, chk_fields} = '1;
		{chk_pcr, chk_psr, chk_ppsr, chk_ppcr, chk_spr, chk_tidr} = '1;
		end_check();

		// General register write and a later read
		take_bits(5, r);
		take_bits(32, d1);
		take_bits(32, pc);
		drive_wb(1'b0, r[4:0], d1, pc);
		step();
		clear_wb();
		exp_pcr = pc;
		chk_pcr = 1'b1;
		take_bits(32, pa);
		drive_dispatch(r[4:0], 1'b0, 32'h0, 1'b0, 1'b0, {pa[31:2], 2'b00}, 1'b0);
		end_check();
		prev_valid = 1'b0;
		exp_src0 = d1;
		exp_valid = 1'b1;
		exp_elock = 1'b0;
		exp_dest = last_dest;
		exp_cmd = last_cmd;
		exp_writeback = 1'b1;
		exp_dest_sys = 1'b0;
		exp_branch = 1'b0;
		{chk_src0, chk_valid, chk_elock, chk_fields} = '1;
		end_check();

		// Writeback forwarding in the dispatch cycle
		take_bits(32, d2);
		take_bits(27, imm);
		imm = {imm[26:0], r[4:0]};
		drive_wb(1'b0, r[4:0], d2, pc);
		drive_dispatch(r[4:0], 1'b0, imm, 1'b0, 1'b1, {pa[31:2], 2'b00}, 1'b0);
		step();
		clear_wb();
		prev_valid = 1'b0;
		exp_src0 = d2;
		exp_src1 = imm;
		{chk_src0, chk_src1} = '1;
		end_check();

		// Identification registers
		drive_dispatch(SYSREG_COREIDR, 1'b1, {27'h0, SYSREG_CPUIDR}, 1'b1, 1'b0, pc, 1'b0);
		step();
		prev_valid = 1'b0;
		exp_src0 = CORE_ID;
		exp_src1 = PROCESSOR_ID_REV;
		{chk_src0, chk_src1} = '1;
		end_check();

		// PCR as a source points one instruction back
		take_bits(32, pb);
		pb = {pb[31:2], 2'b00};
		drive_dispatch(SYSREG_PCR, 1'b1, 32'h0, 1'b0, 1'b0, pb, 1'b0);
		step();
		prev_valid = 1'b0;
		exp_src0 = pb - 32'd4;
		chk_src0 = 1'b1;
		end_check();

		// PCR load from a branch writeback and then a plain one
		take_bits(32, v);
		wb_valid = 1'b1;
		wb_branch = 1'b1;
		wb_branch_pc = v;
		wb_pc = ~v;
		step();
		clear_wb();
		exp_pcr = v;
		chk_pcr = 1'b1;
		end_check();
		take_bits(32, v);
		wb_valid = 1'b1;
		wb_branch_pc = ~v;
		wb_pc = v;
		step();
		clear_wb();
		exp_pcr = v;
		chk_pcr = 1'b1;
		end_check();

		// A latched branch keeps the exception lock
		drive_dispatch(r[4:0], 1'b0, 32'h0, 1'b0, 1'b0, pb, 1'b1);
		step();
		prev_valid = 1'b0;
		exp_elock = 1'b1;
		exp_dest = last_dest;
		exp_cmd = last_cmd;
		exp_branch = 1'b1;
		{chk_elock, chk_fields} = '1;
		end_check();
		drive_dispatch(r[4:0], 1'b0, 32'h0, 1'b0, 1'b0, pb, 1'b0);
		wait_elock_low();
		prev_valid = 1'b0;

		// Stall holds the latched instruction
		pa = {pa[31:2], 2'b00};
		drive_dispatch(r[4:0], 1'b0, 32'h0, 1'b0, 1'b0, pa, 1'b0);
		step();
		next_lock = 1'b1;
		exp_dest = last_dest;
		exp_cmd = last_cmd;
		exp_writeback = 1'b1;
		exp_dest_sys = 1'b0;
		exp_branch = 1'b0;
		drive_dispatch(SYSREG_COREIDR, 1'b1, 32'h0, 1'b0, 1'b0, pb, 1'b0);
		prev_destination_sysreg = 1'b1;
		prev_writeback = 1'b0;
		exp_valid = 1'b0;
		exp_npc = pa;
		exp_src0 = d2;
		{chk_valid, chk_npc, chk_src0, chk_fields} = '1;
		repeat (3) step();
		next_lock = 1'b0;
		clear_checks();
		wait_next_valid();
		prev_valid = 1'b0;
		exp_npc = pb;
		exp_src0 = CORE_ID;
		exp_dest = last_dest;
		exp_cmd = last_cmd;
		exp_writeback = 1'b0;
		exp_dest_sys = 1'b1;
		{chk_npc, chk_src0, chk_fields} = '1;
		end_check();

		// Refresh wins over the lock
		drive_dispatch(r[4:0], 1'b0, 32'h0, 1'b0, 1'b0, pa, 1'b0);
		step();
		refresh = 1'b1;
		next_lock = 1'b1;
		step();
		refresh = 1'b0;
		next_lock = 1'b0;
		prev_valid = 1'b0;
		exp_valid = 1'b0;
		exp_elock = 1'b1;
		exp_npc = '0;
		exp_dest = '0;
		exp_cmd = '0;
		{exp_writeback, exp_dest_sys, exp_branch} = '0;
		{chk_valid, chk_elock, chk_npc, chk_fields} = '1;
		end_check();

		// IRQ entry and exit
		take_bits(32, v);
		drive_wb(1'b1, SYSREG_PSR, v, pc);
		step();
		clear_wb();
		exp_psr = v;
		chk_psr = 1'b1;
		end_check();
		set_irq_mode = 1'b1;
		step();
		set_irq_mode = 1'b0;
		exp_psr = v & ~32'h0000_0064;
		exp_ppsr = v;
		{chk_psr, chk_ppsr} = '1;
		end_check();
		clr_irq_mode = 1'b1;
		step();
		clr_irq_mode = 1'b0;
		exp_psr = v;
		{chk_psr, chk_ppsr} = '1;
		end_check();
		take_bits(32, v);
		ppcr_set = 1'b1;
		ppcr_load = v;
		step();
		ppcr_set = 1'b0;
		exp_ppcr = v;
		chk_ppcr = 1'b1;
		end_check();

		step();
		$display("Run complete: %0d value errors, %0d timeouts", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
verilog/dispatch_pkg.sv
verilog/gr_file.sv
verilog/sysreg_file.sv
verilog/operand_bypass.sv
verilog/dispatch_latch.sv
verilog/dispatch.sv
tb/tb_dispatch.sv
